// ==== rvCore.f ====
verilog/rvPkg.sv
verilog/ctrlIf.sv
verilog/fetchUnit.sv
verilog/decodeUnit.sv
verilog/regFile.sv
verilog/executeUnit.sv
verilog/memAccess.sv
verilog/rvCore.sv
verif/rvCoreTb.sv

// ==== Makefile ====
SIM      = verilator
TOP      = rvCoreTb
FILELIST = rvCore.f
OBJDIR   = obj_dir
FLAGS    = --binary --timing --assert --top-module $(TOP) --Mdir $(OBJDIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== verif/rvCoreTb.sv ====
`timescale 1ns/1ps

module rvCoreTb import rvPkg::*; ();
	bit clk;
	logic rst;
	logic [31:0] imemData;
	logic [31:0] dmemRdata;
	logic [31:0] imemAddr;
	logic [31:0] dmemAddr;
	logic [31:0] dmemWdata;
	logic [3:0] dmemWmask;
	logic dmemWe;
	logic dmemRe;
	logic invalid;
	logic halt;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] expPc [0:255]; // pc of each executed instruction in order
	logic expInv [0:255];
	logic expHalt [0:255];
	logic expRe [0:255];
	logic [31:0] expAddr [0:63];
	logic [31:0] expWdata [0:63];
	logic [3:0] expMask [0:63];
	logic [7:0] progLen;
	logic [7:0] nExec;
	logic [5:0] nStores;
	logic [7:0] execIdx;
	logic [5:0] storeIdx;
	logic [11:0] resultOff;
	logic [31:0] opA;
	logic [31:0] opB;
	int cycles = 0;

	rvCore u_rvCore (
		.clk(clk),
		.rst(rst),
		.imemData(imemData),
		.dmemRdata(dmemRdata),
		.imemAddr(imemAddr),
		.dmemAddr(dmemAddr),
		.dmemWdata(dmemWdata),
		.dmemWmask(dmemWmask),
		.dmemWe(dmemWe),
		.dmemRe(dmemRe),
		.invalid(invalid),
		.halt(halt)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	// both memories answer in the same cycle
	assign imemData = imem[imemAddr[9:2]];
	assign dmemRdata = dmem[dmemAddr[9:2]];

	always @(posedge clk) begin
		if (dmemWe)
			dmem[dmemAddr[9:2]] <= (dmem[dmemAddr[9:2]] & ~laneBits(dmemWmask)) |
				(dmemWdata & laneBits(dmemWmask));
	end

	always @(posedge clk) begin
		if (!rst)
			execIdx <= 8'd0;
		else if (!halt)
			execIdx <= execIdx + 8'd1;
		if (!rst)
			storeIdx <= 6'd0;
		else if (dmemWe)
			storeIdx <= storeIdx + 6'd1;
	end

	always @(posedge clk) begin
		if (rst)
			cycles <= cycles + 1;
		if (cycles > 2 * int'(progLen) + 20)
			stopRun("Timeout, the core never reached ebreak");
	end

	resetPcCheck: assert property (@(negedge clk) !rst |-> imemAddr == resetPc)
		else reportMismatch("imemAddr", $sampled(imemAddr), resetPc);
	resetQuiet: assert property (@(negedge clk) !rst |-> !(dmemWe || dmemRe || halt || invalid))
		else stopRun("Error: a strobe or flag was high during reset");
	pcTrace: assert property (@(posedge clk) disable iff (!rst) imemAddr == expPc[execIdx])
		else reportMismatch("imemAddr", $sampled(imemAddr), expPc[$sampled(execIdx)]);
	invalidFlag: assert property (@(posedge clk) disable iff (!rst) invalid == expInv[execIdx])
		else reportMismatch("invalid", {31'b0, $sampled(invalid)},
			{31'b0, expInv[$sampled(execIdx)]});
	haltFlag: assert property (@(posedge clk) disable iff (!rst) halt == expHalt[execIdx])
		else reportMismatch("halt", {31'b0, $sampled(halt)},
			{31'b0, expHalt[$sampled(execIdx)]});
	readStrobe: assert property (@(posedge clk) disable iff (!rst) dmemRe == expRe[execIdx])
		else reportMismatch("dmemRe", {31'b0, $sampled(dmemRe)},
			{31'b0, expRe[$sampled(execIdx)]});
	storeKnown: assert property (@(posedge clk) disable iff (!rst) dmemWe |-> storeIdx < nStores)
		else stopRun("Error: the core made a store that the program does not contain");
	storeAddrCheck: assert property (@(posedge clk) disable iff (!rst)
		dmemWe |-> dmemAddr == expAddr[storeIdx])
		else reportMismatch("dmemAddr", $sampled(dmemAddr), expAddr[$sampled(storeIdx)]);
	storeDataCheck: assert property (@(posedge clk) disable iff (!rst)
		dmemWe |-> dmemWdata == expWdata[storeIdx])
		else reportMismatch("dmemWdata", $sampled(dmemWdata), expWdata[$sampled(storeIdx)]);
	storeMaskCheck: assert property (@(posedge clk) disable iff (!rst)
		dmemWe |-> dmemWmask == expMask[storeIdx])
		else reportMismatch("dmemWmask", {28'b0, $sampled(dmemWmask)},
			{28'b0, expMask[$sampled(storeIdx)]});
	haltQuiet: assert property (@(posedge clk) disable iff (!rst) halt |-> !dmemWe)
		else stopRun("Error: store strobe high while halted");

	task automatic stopRun(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		stopRun($sformatf("Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp));
	endtask

	function automatic logic [31:0] laneBits(input logic [3:0] mask);
		return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
	endfunction

	function automatic logic [31:0] regOpWord(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] immWord(input logic [6:0] op, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] storeWord(input logic [2:0] f3, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] beqWord(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jalWord(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	// RV32I result rule where alt is funct7 bit 5 of sub and sra
	function automatic logic [31:0] aluRule(input logic alt, input logic [2:0] f3,
		input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = {31'b0, $signed(a) < $signed(b)};
			3'd3: r = {31'b0, a < b};
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt)
					r = $signed(a) >>> b[4:0];
				else
					r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic logic [31:0] slotPc(input logic [7:0] slot);
		return resetPc + {22'b0, slot, 2'b00};
	endfunction

	task automatic emit(input logic [31:0] word, input logic run);
		imem[progLen] = word;
		if (run) begin // skipped slots stay out of the trace
			expPc[nExec] = slotPc(progLen);
			expInv[nExec] = 1'b0;
			expHalt[nExec] = 1'b0;
			expRe[nExec] = (word[6:0] == 7'b0000011); // loads read data memory
			nExec = nExec + 8'd1;
		end
		progLen = progLen + 8'd1;
	endtask

	task automatic emitFlagged(input logic [31:0] word, input logic inv, input logic hlt);
		emit(word, 1'b1);
		expInv[nExec - 8'd1] = inv;
		expHalt[nExec - 8'd1] = hlt;
	endtask

	task automatic skipSlot();
		emit(storeWord(3'b010, 5'd3, 5'd0, 12'h000), 1'b0); // would store if reached
	endtask

	task automatic expectStore(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] mask);
		expAddr[nStores] = addr;
		expWdata[nStores] = data;
		expMask[nStores] = mask;
		nStores = nStores + 6'd1;
	endtask

	task automatic storeResult(input logic [4:0] rs, input logic [31:0] value);
		emit(storeWord(3'b010, rs, 5'd2, resultOff), 1'b1);
		expectStore(32'h200 + {20'b0, resultOff}, value, 4'hf);
		resultOff = resultOff + 12'd4;
	endtask

	task automatic buildProgram();
		logic [31:0] rnd;
		logic [31:0] shifted;
		logic [31:0] src;
		logic [31:0] here;
		logic [31:0] jalLink;
		logic [11:0] imm;
		emit(immWord(7'b0010011, 3'b000, 5'd1, 5'd0, 12'h100), 1'b1); // operand base
		emit(immWord(7'b0010011, 3'b000, 5'd2, 5'd0, 12'h200), 1'b1); // result base
		emit(immWord(7'b0010011, 3'b000, 5'd6, 5'd0, 12'h300), 1'b1); // scratch word
		emit(immWord(7'b0000011, 3'b010, 5'd3, 5'd1, 12'h000), 1'b1);
		emit(immWord(7'b0000011, 3'b010, 5'd4, 5'd1, 12'h004), 1'b1);
		for (int f = 0; f < 8; f++) begin
			emit(regOpWord(7'b0000000, f[2:0], 5'd5, 5'd3, 5'd4), 1'b1);
			storeResult(5'd5, aluRule(1'b0, f[2:0], opA, opB));
			if (f == 0 || f == 5) begin
				emit(regOpWord(7'b0100000, f[2:0], 5'd5, 5'd3, 5'd4), 1'b1);
				storeResult(5'd5, aluRule(1'b1, f[2:0], opA, opB));
			end
		end
		for (int f = 0; f < 8; f++) begin
			if (f != 1 && f != 5) begin
				rnd = $urandom();
				imm = rnd[11:0];
				emit(immWord(7'b0010011, f[2:0], 5'd5, 5'd3, imm), 1'b1);
				storeResult(5'd5, aluRule(1'b0, f[2:0], opA, {{20{imm[11]}}, imm}));
			end
		end
		for (int k = 0; k < 4; k++) begin
			shifted = opA >> (8 * k);
			emit(immWord(7'b0000011, 3'b000, 5'd5, 5'd1, {10'b0, k[1:0]}), 1'b1); // lb
			storeResult(5'd5, {{24{shifted[7]}}, shifted[7:0]});
			emit(immWord(7'b0000011, 3'b100, 5'd5, 5'd1, {10'b0, k[1:0]}), 1'b1); // lbu
			storeResult(5'd5, {24'b0, shifted[7:0]});
			if (k == 0 || k == 2) begin
				emit(immWord(7'b0000011, 3'b001, 5'd5, 5'd1, {10'b0, k[1:0]}), 1'b1);
				storeResult(5'd5, {{16{shifted[15]}}, shifted[15:0]});
				emit(immWord(7'b0000011, 3'b101, 5'd5, 5'd1, {10'b0, k[1:0]}), 1'b1);
				storeResult(5'd5, {16'b0, shifted[15:0]});
			end
		end
		for (int k = 0; k < 4; k++) begin
			src = k[0] ? opA : opB; // odd lanes take x3
			emit(storeWord(3'b000, k[0] ? 5'd3 : 5'd4, 5'd6, {10'b0, k[1:0]}), 1'b1);
			expectStore(32'h300 + k, {24'b0, src[7:0]} << (8 * k), 4'b0001 << k);
		end
		emit(storeWord(3'b001, 5'd4, 5'd6, 12'h004), 1'b1);
		expectStore(32'h304, {16'b0, opB[15:0]}, 4'b0011);
		emit(storeWord(3'b001, 5'd3, 5'd6, 12'h006), 1'b1);
		expectStore(32'h306, {opA[15:0], 16'b0}, 4'b1100);
		emit(immWord(7'b0000011, 3'b010, 5'd5, 5'd6, 12'h000), 1'b1);
		storeResult(5'd5, {opA[7:0], opB[7:0], opA[7:0], opB[7:0]});
		emit(immWord(7'b0000011, 3'b010, 5'd5, 5'd6, 12'h004), 1'b1);
		storeResult(5'd5, {opA[15:0], opB[15:0]});
		rnd = $urandom();
		emit({rnd[31:12], 5'd5, 7'b0110111}, 1'b1); // lui
		storeResult(5'd5, {rnd[31:12], 12'b0});
		rnd = $urandom();
		here = slotPc(progLen);
		emit({rnd[31:12], 5'd5, 7'b0010111}, 1'b1); // auipc
		storeResult(5'd5, here + {rnd[31:12], 12'b0});
		emit(beqWord(5'd3, 5'd4, 13'd8), 1'b1); // operands differ so it falls through
		emit(beqWord(5'd3, 5'd3, 13'd8), 1'b1);
		skipSlot();
		jalLink = slotPc(progLen) + 32'd4;
		emit(jalWord(5'd7, 21'd8), 1'b1);
		skipSlot();
		storeResult(5'd7, jalLink);
		emit({20'h00000, 5'd8, 7'b0010111}, 1'b1); // auipc x8, 0
		here = slotPc(progLen) + 32'd4;
		emit(immWord(7'b1100111, 3'b000, 5'd9, 5'd8, 12'd13), 1'b1); // odd offset loses bit 0
		skipSlot();
		storeResult(5'd9, here);
		emitFlagged(immWord(7'b0010011, 3'b001, 5'd7, 5'd3, 12'd1), 1'b1, 1'b0); // slli
		emitFlagged(32'h3400_1073, 1'b1, 1'b0); // csrrw
		storeResult(5'd7, jalLink); // x7 untouched by the slli
		emitFlagged(32'h0010_0073, 1'b0, 1'b1);
		skipSlot();
	endtask

	initial begin
		void'($urandom(32'h3b2f_4db2));
		rst = 1'b0;
		progLen = 8'd0;
		nExec = 8'd0;
		nStores = 6'd0;
		resultOff = 12'd0;
		opA = $urandom();
		opB = $urandom();
		if (opB == opA)
			opB = ~opA;
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0;
			dmem[i] = {4{i[7:0]}} ^ 32'h9e37_79b9;
		end
		dmem[8'h40] = opA;
		dmem[8'h41] = opB;
		buildProgram();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		while (!halt)
			@(negedge clk);
		repeat (4) @(negedge clk); // core must stay stopped
		if (storeIdx == nStores) begin
			$display("SIMULATION PASSED");
			$finish;
		end else
			stopRun($sformatf("Error: %0d of %0d stores happened", storeIdx, nStores));
	end

endmodule

// ==== verilog/rvCore.sv ====
`timescale 1ns/1ps

module rvCore import rvPkg::*; (
	input logic clk,
	input logic rst,
	input logic [31:0] imemData,
	input logic [31:0] dmemRdata,
	output logic [31:0] imemAddr,
	output logic [31:0] dmemAddr,
	output logic [31:0] dmemWdata,
	output logic [3:0] dmemWmask,
	output logic dmemWe,
	output logic dmemRe,
	output logic invalid,
	output logic halt
);
	logic [xlen-1:0] pc;
	logic [xlen-1:0] pcPlus4;
	logic [xlen-1:0] aluResult;
	logic [xlen-1:0] branchTarget;
	logic [xlen-1:0] rdata1;
	logic [xlen-1:0] rdata2;
	logic [xlen-1:0] wbData;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd;
	logic zero;

	ctrlIf ctrl();

	assign imemAddr = pc; // instruction fetched straight from pc

	fetchUnit u_fetchUnit (
		.clk(clk),
		.rst(rst),
		.halt(halt),
		.ctrl(ctrl.fetch),
		.zero(zero),
		.branchTarget(branchTarget),
		.aluResult(aluResult),
		.pc(pc),
		.pcPlus4(pcPlus4)
	);

	decodeUnit u_decodeUnit (
		.rst(rst),
		.inst(imemData),
		.ctrl(ctrl.decoder),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.invalid(invalid),
		.halt(halt)
	);

	regFile u_regFile (
		.clk(clk),
		.rst(rst),
		.we(ctrl.regWrite),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.wdata(wbData),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	executeUnit u_executeUnit (
		.ctrl(ctrl.exec),
		.pc(pc),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.aluResult(aluResult),
		.zero(zero),
		.branchTarget(branchTarget)
	);

	memAccess u_memAccess (
		.ctrl(ctrl.mem),
		.aluResult(aluResult),
		.storeData(rdata2), // rs2 holds store data
		.dmemRdata(dmemRdata),
		.pcPlus4(pcPlus4),
		.branchTarget(branchTarget),
		.dmemAddr(dmemAddr),
		.dmemWdata(dmemWdata),
		.dmemWmask(dmemWmask),
		.dmemWe(dmemWe),
		.dmemRe(dmemRe),
		.wbData(wbData)
	);

endmodule

// ==== verilog/memAccess.sv ====
`timescale 1ns/1ps

module memAccess import rvPkg::*; (
	ctrlIf.mem ctrl,
	input logic [31:0] aluResult,
	input logic [31:0] storeData,
	input logic [31:0] dmemRdata,
	input logic [31:0] pcPlus4,
	input logic [31:0] branchTarget,
	output logic [31:0] dmemAddr,
	output logic [31:0] dmemWdata,
	output logic [3:0] dmemWmask,
	output logic dmemWe,
	output logic dmemRe,
	output logic [31:0] wbData
);
	logic [1:0] lane;
	logic [7:0] loadByte;
	logic [15:0] loadHalf;
	logic [xlen-1:0] loadData;

	assign dmemAddr = aluResult;
	assign lane = aluResult[1:0];
	assign dmemWe = ctrl.memWrite;
	assign dmemRe = ctrl.memRead;

	// move store data up to the addressed lane
	always_comb begin
		case (ctrl.memSize)
			sizeByte: begin
				dmemWdata = {24'b0, storeData[7:0]} << {lane, 3'b000};
				dmemWmask = 4'b0001 << lane;
			end
			sizeHalf: begin
				dmemWdata = {16'b0, storeData[15:0]} << {lane[1], 4'b0000};
				dmemWmask = 4'b0011 << {lane[1], 1'b0};
			end
			default: begin
				dmemWdata = storeData;
				dmemWmask = 4'b1111;
			end
		endcase
	end

	assign loadByte = dmemRdata[{lane, 3'b000} +: 8];
	assign loadHalf = dmemRdata[{lane[1], 4'b0000} +: 16];

	always_comb begin
		case (ctrl.memSize)
			sizeByte: loadData = ctrl.memUnsigned ? {24'b0, loadByte} :
				{{24{loadByte[7]}}, loadByte};
			sizeHalf: loadData = ctrl.memUnsigned ? {16'b0, loadHalf} :
				{{16{loadHalf[15]}}, loadHalf};
			default: loadData = dmemRdata;
		endcase
	end

	always_comb begin
		case (ctrl.wbSel)
			wbMem: wbData = loadData;
			wbPcPlus4: wbData = pcPlus4; // link value
			wbPcImm: wbData = branchTarget;
			default: wbData = aluResult;
		endcase
	end

endmodule

// ==== verilog/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit import rvPkg::*; (
	ctrlIf.exec ctrl,
	input logic [31:0] pc,
	input logic [31:0] rdata1,
	input logic [31:0] rdata2,
	output logic [31:0] aluResult,
	output logic zero,
	output logic [31:0] branchTarget
);
	logic [xlen-1:0] srcB;
	logic [4:0] shamt;

	assign srcB = ctrl.aluSrcImm ? ctrl.imm : rdata2;
	assign shamt = srcB[4:0];

	always_comb begin
		case (ctrl.aluOp)
			aluAdd: aluResult = rdata1 + srcB;
			aluSub: aluResult = rdata1 - srcB;
			aluSll: aluResult = rdata1 << shamt;
			aluSlt: aluResult = {{(xlen-1){1'b0}}, $signed(rdata1) < $signed(srcB)};
			aluSltu: aluResult = {{(xlen-1){1'b0}}, rdata1 < srcB};
			aluXor: aluResult = rdata1 ^ srcB;
			aluSrl: aluResult = rdata1 >> shamt;
			aluSra: aluResult = $signed(rdata1) >>> shamt;
			aluOr: aluResult = rdata1 | srcB;
			aluAnd: aluResult = rdata1 & srcB;
			aluPassB: aluResult = srcB; // lui upper immediate
			default: aluResult = '0;
		endcase
	end

	assign zero = (aluResult == '0);

	// beq and jal target and the auipc result
	assign branchTarget = pc + ctrl.imm;

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps

module regFile import rvPkg::*; (
	input logic clk,
	input logic rst,
	input logic we,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	input logic [4:0] rd,
	input logic [31:0] wdata,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);
	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	// x0 hardwired
	assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== verilog/decodeUnit.sv ====
`timescale 1ns/1ps

module decodeUnit import rvPkg::*; (
	input logic rst,
	input instWord inst,
	ctrlIf.decoder ctrl,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd,
	output logic invalid,
	output logic halt
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic valid;
	logic isEbreak;
	logic allowWrite;
	logic [3:0] aluFunct;
	logic [xlen-1:0] immI;
	logic [xlen-1:0] immS;
	logic [xlen-1:0] immB;
	logic [xlen-1:0] immU;
	logic [xlen-1:0] immJ;
	logic regWriteRaw;
	logic memReadRaw;
	logic memWriteRaw;
	logic branchRaw;
	logic jalRaw;
	logic jalrRaw;

	assign opcode = inst.rType.opcode;
	assign funct3 = inst.rType.funct3;
	assign funct7 = inst.rType.funct7;
	assign rs1 = inst.rType.rs1;
	assign rs2 = inst.rType.rs2;
	assign rd = inst.rType.rd;

	assign immI = {{20{inst.iType.imm[11]}}, inst.iType.imm};
	assign immS = {{20{inst.sType.immHi[6]}}, inst.sType.immHi, inst.sType.immLo};
	assign immB = {{19{inst.bType.imm12}}, inst.bType.imm12, inst.bType.imm11,
		inst.bType.imm10to5, inst.bType.imm4to1, 1'b0};
	assign immU = {inst.uType.imm, 12'b0};
	assign immJ = {{11{inst.jType.imm20}}, inst.jType.imm20, inst.jType.imm19to12,
		inst.jType.imm11, inst.jType.imm10to1, 1'b0};

	assign isEbreak = (inst == ebreakWord);

	always_comb begin
		case (opcode)
			opLui, opAuipc, opJal: valid = 1'b1;
			opJalr, opBranch: valid = (funct3 == 3'b000); // jalr and beq only
			opLoad: valid = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
			opStore: valid = funct3 inside {3'b000, 3'b001, 3'b010};
			opImm: valid = (funct3 != 3'b001) && (funct3 != 3'b101); // no shift-immediates
			opReg: valid = (funct7 == 7'b0000000) ||
				((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
			opSystem: valid = isEbreak;
			default: valid = 1'b0;
		endcase
	end

	assign invalid = rst && !valid;
	assign halt = rst && isEbreak;
	assign allowWrite = rst && valid && !isEbreak;

	// funct7 bit 5 picks sub and sra on R-type only
	always_comb begin
		case (funct3)
			3'b000: aluFunct = (opcode == opReg && funct7[5]) ? aluSub : aluAdd;
			3'b001: aluFunct = aluSll;
			3'b010: aluFunct = aluSlt;
			3'b011: aluFunct = aluSltu;
			3'b100: aluFunct = aluXor;
			3'b101: aluFunct = funct7[5] ? aluSra : aluSrl;
			3'b110: aluFunct = aluOr;
			default: aluFunct = aluAnd;
		endcase
	end

	always_comb begin
		ctrl.aluOp = aluAdd;
		ctrl.aluSrcImm = 1'b0;
		ctrl.imm = immI;
		ctrl.wbSel = wbAlu;
		ctrl.memUnsigned = funct3[2]; // lbu and lhu
		regWriteRaw = 1'b0;
		memReadRaw = 1'b0;
		memWriteRaw = 1'b0;
		branchRaw = 1'b0;
		jalRaw = 1'b0;
		jalrRaw = 1'b0;
		case (funct3[1:0])
			2'b00: ctrl.memSize = sizeByte;
			2'b01: ctrl.memSize = sizeHalf;
			default: ctrl.memSize = sizeWord;
		endcase
		case (opcode)
			opLui: begin
				ctrl.aluOp = aluPassB;
				ctrl.aluSrcImm = 1'b1;
				ctrl.imm = immU;
				regWriteRaw = 1'b1;
			end
			opAuipc: begin
				ctrl.imm = immU;
				ctrl.wbSel = wbPcImm;
				regWriteRaw = 1'b1;
			end
			opJal: begin
				ctrl.imm = immJ;
				ctrl.wbSel = wbPcPlus4;
				regWriteRaw = 1'b1;
				jalRaw = 1'b1;
			end
			opJalr: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.wbSel = wbPcPlus4;
				regWriteRaw = 1'b1;
				jalrRaw = 1'b1;
			end
			opBranch: begin
				ctrl.aluOp = aluSub; // zero flag means equal
				ctrl.imm = immB;
				branchRaw = 1'b1;
			end
			opLoad: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.wbSel = wbMem;
				regWriteRaw = 1'b1;
				memReadRaw = 1'b1;
			end
			opStore: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.imm = immS;
				memWriteRaw = 1'b1;
			end
			opImm: begin
				ctrl.aluOp = aluFunct;
				ctrl.aluSrcImm = 1'b1;
				regWriteRaw = 1'b1;
			end
			opReg: begin
				ctrl.aluOp = aluFunct;
				regWriteRaw = 1'b1;
			end
			default: ;
		endcase
	end

	// nothing commits in reset, on ebreak or on an unknown word
	assign ctrl.regWrite = regWriteRaw && allowWrite;
	assign ctrl.memRead = memReadRaw && allowWrite;
	assign ctrl.memWrite = memWriteRaw && allowWrite;
	assign ctrl.branch = branchRaw && allowWrite;
	assign ctrl.jal = jalRaw && allowWrite;
	assign ctrl.jalr = jalrRaw && allowWrite;

endmodule

// ==== verilog/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit import rvPkg::*; (
	input logic clk,
	input logic rst,
	input logic halt,
	ctrlIf.fetch ctrl,
	input logic zero,
	input logic [31:0] branchTarget,
	input logic [31:0] aluResult,
	output logic [31:0] pc,
	output logic [31:0] pcPlus4
);
	logic [1:0] pcSel;
	logic [xlen-1:0] nextPc;

	assign pcPlus4 = pc + 32'd4;

	always_comb begin
		if (ctrl.jalr)
			pcSel = rvPkg::pcJalr;
		else if (ctrl.jal || (ctrl.branch && zero)) // beq taken when rs1 - rs2 is zero
			pcSel = rvPkg::pcBranch;
		else
			pcSel = rvPkg::pcPlus4;
	end

	always_comb begin
		case (pcSel)
			rvPkg::pcBranch: nextPc = branchTarget;
			rvPkg::pcJalr: nextPc = {aluResult[31:1], 1'b0};
			default: nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst)
			pc <= resetPc;
		else if (!halt) // ebreak freezes the core until reset
			pc <= nextPc;
	end

	pcAligned: assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00);

endmodule

// ==== verilog/ctrlIf.sv ====
`timescale 1ns/1ps

interface ctrlIf import rvPkg::*; ();
	logic [3:0] aluOp;
	logic aluSrcImm; // second operand is the immediate
	logic [xlen-1:0] imm;
	logic regWrite;
	logic [1:0] wbSel;
	logic memRead;
	logic memWrite;
	logic [1:0] memSize;
	logic memUnsigned;
	logic branch;
	logic jalr;
	logic jal;

	modport decoder(
		output aluOp, aluSrcImm, imm, regWrite, wbSel, memRead, memWrite,
		output memSize, memUnsigned, branch, jalr, jal
	);
	modport fetch(input branch, jal, jalr);
	modport exec(input aluOp, aluSrcImm, imm);
	modport mem(input memRead, memWrite, memSize, memUnsigned, wbSel);
endinterface

// ==== verilog/rvPkg.sv ====
package rvPkg;

	localparam int xlen = 32;
	localparam logic [31:0] resetPc = 32'h8000_0000;

	// major opcodes
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opReg = 7'b0110011;
	localparam logic [6:0] opSystem = 7'b1110011;

	localparam logic [31:0] ebreakWord = 32'h0010_0073; // only system word accepted

	localparam logic [3:0] aluAdd = 4'd0;
	localparam logic [3:0] aluSub = 4'd1;
	localparam logic [3:0] aluSll = 4'd2;
	localparam logic [3:0] aluSlt = 4'd3;
	localparam logic [3:0] aluSltu = 4'd4;
	localparam logic [3:0] aluXor = 4'd5;
	localparam logic [3:0] aluSrl = 4'd6;
	localparam logic [3:0] aluSra = 4'd7;
	localparam logic [3:0] aluOr = 4'd8;
	localparam logic [3:0] aluAnd = 4'd9;
	localparam logic [3:0] aluPassB = 4'd10; // lui

	// writeback source
	localparam logic [1:0] wbAlu = 2'd0;
	localparam logic [1:0] wbMem = 2'd1;
	localparam logic [1:0] wbPcPlus4 = 2'd2;
	localparam logic [1:0] wbPcImm = 2'd3; // auipc

	// matches funct3[1:0] of loads and stores
	localparam logic [1:0] sizeByte = 2'd0;
	localparam logic [1:0] sizeHalf = 2'd1;
	localparam logic [1:0] sizeWord = 2'd2;

	localparam logic [1:0] pcPlus4 = 2'd0;
	localparam logic [1:0] pcBranch = 2'd1;
	localparam logic [1:0] pcJalr = 2'd2;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rTypeFields;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} iTypeFields;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sTypeFields;

	// branch offset bits are scattered across the word
	typedef struct packed {
		logic imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic imm11;
		logic [6:0] opcode;
	} bTypeFields;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} uTypeFields;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10to1;
		logic imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jTypeFields;

	typedef union packed {
		rTypeFields rType;
		iTypeFields iType;
		sTypeFields sType;
		bTypeFields bType;
		uTypeFields uType;
		jTypeFields jType;
	} instWord;

endpackage
